// ==== project.f ====
verilog/core_pkg.sv
verilog/core_gpr.sv
verilog/core_ifu.sv
verilog/core_idu.sv
verilog/core_exu.sv
verilog/core_top.sv
testbench/core_tb.sv

// ==== Makefile ====
TOP = core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f verilog/*.sv testbench/*.sv
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)

clean:
	rm -rf obj_dir

// ==== testbench/core_tb.sv ====
// Core testbench
`timescale 1ns/1ps
`default_nettype none

module core_tb;
	import core_pkg::*;

	localparam word_t RESET_PC = 32'h0000_0100;
	localparam int NUM_RETIRES = 2000;
	localparam int RESET_CYCLES = 16;
	localparam int WATCHDOG_CYCLES = NUM_RETIRES * 10;

	logic clk;
	logic reset;
	logic fetch_addr_vld;
	word_t fetch_addr;
	logic fetch_inst_vld;
	word_t fetch_inst;
	logic retire_vld;
	retire_t retire;

	integer seed;
	word_t model_regs [0:31];
	word_t model_pc;

	core_top #(
		.RESET_PC(RESET_PC)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.fetch_addr_vld(fetch_addr_vld),
		.fetch_addr(fetch_addr),
		.fetch_inst_vld(fetch_inst_vld),
		.fetch_inst(fetch_inst),
		.retire_vld(retire_vld),
		.retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic mismatch(input string name, input word_t got, input word_t exp);
		$display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
		$display("Result: FAILED");
		$fatal(1, "wrong value");
	endtask

	task automatic protocol_error(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Result: FAILED");
		$fatal(1, "protocol error");
	endtask

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// random instruction with about 10% unsupported opcodes
	function automatic word_t random_inst();
		word_t r;
		word_t v;
		logic [2:0] f3;
		logic [11:0] imm12;
		opcode_t opc;
		int unsigned pick;
		r = rand_word();
		v = rand_word();
		f3 = r[14:12];
		pick = rand_below(100);
		if (pick < 8) begin
			return {v[31:12], r[11:7], OPC_LUI};
		end else if (pick < 16) begin
			return {v[31:12], r[11:7], OPC_AUIPC};
		end else if (pick < 24) begin
			return {v[20], v[10:1], v[11], v[19:12], r[11:7], OPC_JAL};
		end else if (pick < 32) begin
			return {v[11:0], r[19:15], 3'b000, r[11:7], OPC_JALR};
		end else if (pick < 50) begin
			// 010 and 011 are no branches
			if (f3[2:1] == 2'b01) f3[2] = 1'b1;
			return {v[12], v[10:5], r[24:20], r[19:15], f3, v[4:1], v[11], OPC_BRANCH};
		end else if (pick < 70) begin
			imm12 = v[11:0];
			if (f3 == 3'b001) imm12 = {7'b0, v[4:0]};
			if (f3 == 3'b101) imm12 = {1'b0, v[10], 5'b0, v[4:0]};
			return {imm12, r[19:15], f3, r[11:7], OPC_OP_IMM};
		end else if (pick < 90) begin
			return {1'b0, v[10] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
				r[24:20], r[19:15], f3, r[11:7], OPC_OP};
		end
		case (rand_below(4))
			0: opc = 7'b0000011;
			1: opc = 7'b0100011;
			2: opc = 7'b0001111;
			default: opc = 7'b1110011;
		endcase
		return {r[31:7], opc};
	endfunction

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
			input word_t a, input word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt) return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic model_exec(input word_t inst, output logic we, output reg_idx_t rd,
			output word_t data, output word_t next_pc);
		word_t a;
		word_t b;
		word_t imm_i;
		word_t imm_u;
		word_t imm_j;
		word_t imm_b;
		logic taken;
		a = model_regs[inst[19:15]];
		b = model_regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_u = {inst[31:12], 12'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		we = 1'b0;
		rd = inst[11:7];
		data = '0;
		next_pc = model_pc + 32'd4;
		case (inst[6:0])
			OPC_LUI: begin
				we = 1'b1;
				data = imm_u;
			end
			OPC_AUIPC: begin
				we = 1'b1;
				data = model_pc + imm_u;
			end
			OPC_JAL: begin
				we = 1'b1;
				data = model_pc + 32'd4;
				next_pc = (model_pc + imm_j) & ~32'd3;
			end
			OPC_JALR: begin
				we = 1'b1;
				data = model_pc + 32'd4;
				next_pc = (a + imm_i) & ~32'd3;
			end
			OPC_BRANCH: begin
				case (inst[14:12])
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					3'b111: taken = (a >= b);
					default: taken = 1'b0;
				endcase
				if (taken) next_pc = (model_pc + imm_b) & ~32'd3;
			end
			OPC_OP_IMM: begin
				we = 1'b1;
				data = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, imm_i);
			end
			OPC_OP: begin
				we = 1'b1;
				data = alu_ref(inst[14:12], inst[30], a, b);
			end
			default: we = 1'b0;
		endcase
	endtask

	// answer the open request, then check the retire record
	task automatic run_one(input word_t inst);
		int unsigned delay;
		int n;
		logic exp_we;
		reg_idx_t exp_rd;
		word_t exp_data;
		word_t exp_next;
		assert (fetch_addr_vld === 1'b1) else protocol_error("no fetch request open");
		assert (fetch_addr === model_pc) else mismatch("fetch_addr", fetch_addr, model_pc);
		delay = rand_below(4);
		repeat (delay) begin
			@(negedge clk);
			assert (fetch_addr_vld === 1'b1) else protocol_error("fetch request dropped early");
			assert (fetch_addr === model_pc) else mismatch("fetch_addr", fetch_addr, model_pc);
		end
		fetch_inst_vld = 1'b1;
		fetch_inst = inst;
		model_exec(inst, exp_we, exp_rd, exp_data, exp_next);
		for (n = 1; n <= 3; n++) begin
			@(negedge clk);
			fetch_inst_vld = 1'b0;
			fetch_inst = '0;
			assert (fetch_addr_vld === 1'b0)
				else protocol_error("fetch request held after answer");
			if (n < 3) begin
				assert (retire_vld === 1'b0) else protocol_error("retire came too early");
			end
		end
		assert (retire_vld === 1'b1) else protocol_error("no retire 3 cycles after fetch");
		assert (retire.pc === model_pc) else mismatch("retire.pc", retire.pc, model_pc);
		assert (retire.rd_we === exp_we)
			else mismatch("retire.rd_we", word_t'(retire.rd_we), word_t'(exp_we));
		if (exp_we) begin
			assert (retire.rd_idx === exp_rd)
				else mismatch("retire.rd_idx", word_t'(retire.rd_idx), word_t'(exp_rd));
			assert (retire.rd_data === exp_data)
				else mismatch("retire.rd_data", retire.rd_data, exp_data);
		end
		assert (retire.next_pc === exp_next)
			else mismatch("retire.next_pc", retire.next_pc, exp_next);
		if (exp_we && exp_rd != 5'd0) model_regs[exp_rd] = exp_data;
		model_pc = exp_next;
		@(negedge clk);
		assert (retire_vld === 1'b0) else protocol_error("retire longer than one cycle");
		assert (fetch_addr_vld === 1'b1)
			else protocol_error("no fetch in the cycle after retire");
		assert (fetch_addr === model_pc) else mismatch("fetch_addr", fetch_addr, model_pc);
	endtask

	initial begin
		int i;
		word_t upper;
		seed = 98948;
		reset = 1'b1;
		fetch_inst_vld = 1'b0;
		fetch_inst = '0;
		model_pc = RESET_PC;
		for (i = 0; i < 32; i++) model_regs[i] = '0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			assert (fetch_addr_vld === 1'b0 && retire_vld === 1'b0)
				else protocol_error("bus or retire active during reset");
		end
		reset = 1'b0;
		@(negedge clk);
		assert (fetch_addr_vld === 1'b1)
			else protocol_error("no fetch in the first cycle after reset");
		assert (fetch_addr === RESET_PC) else mismatch("fetch_addr", fetch_addr, RESET_PC);
		// load every register before random code reads it
		for (i = 1; i < 32; i++) begin
			upper = rand_word();
			run_one({upper[31:12], reg_idx_t'(i), OPC_LUI});
		end
		for (i = 31; i < NUM_RETIRES; i++) begin
			run_one(random_inst());
		end
		$display("%0d instructions retired", NUM_RETIRES);
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles",
			RESET_CYCLES + WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// ==== verilog/core_top.sv ====
// Core top level
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	output logic fetch_addr_vld,
	output core_pkg::word_t fetch_addr,
	input logic fetch_inst_vld,
	input core_pkg::word_t fetch_inst,
	output logic retire_vld,
	output core_pkg::retire_t retire
);
	import core_pkg::*;

	logic item_vld;
	fetch_item_t item;
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	word_t rs1_val;
	word_t rs2_val;
	logic op_vld;
	decoded_op_t op;

	core_ifu #(
		.RESET_PC(RESET_PC)
	) ifu_i (
		.clk(clk),
		.reset(reset),
		.fetch_addr_vld(fetch_addr_vld),
		.fetch_addr(fetch_addr),
		.fetch_inst_vld(fetch_inst_vld),
		.fetch_inst(fetch_inst),
		.retire_vld(retire_vld),
		.retire(retire),
		.item_vld(item_vld),
		.item(item)
	);

	core_idu idu_i (
		.clk(clk),
		.reset(reset),
		.item_vld(item_vld),
		.item(item),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.op_vld(op_vld),
		.op(op)
	);

	core_exu exu_i (
		.clk(clk),
		.reset(reset),
		.op_vld(op_vld),
		.op(op),
		.retire_vld(retire_vld),
		.retire(retire)
	);

	core_gpr gpr_i (
		.clk(clk),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.retire_vld(retire_vld),
		.retire(retire)
	);

endmodule

`default_nettype wire

// ==== verilog/core_exu.sv ====
// Execute unit
`timescale 1ns/1ps
`default_nettype none

module core_exu (
	input logic clk,
	input logic reset,
	input logic op_vld,
	input core_pkg::decoded_op_t op,
	output logic retire_vld,
	output core_pkg::retire_t retire
);
	import core_pkg::*;

	word_t alu_b;
	word_t alu_res;
	word_t pc_seq;
	word_t pc_rel;
	logic taken;
	retire_t rec;

	assign alu_b = (op.op_class == CLS_ALU_REG) ? op.rs2_val : op.imm;
	assign pc_seq = op.pc + 32'd4;
	assign pc_rel = op.pc + op.imm;

	always_comb begin
		case (op.alu_op)
			ADD: alu_res = op.rs1_val + alu_b;
			SUB: alu_res = op.rs1_val - alu_b;
			SLL: alu_res = op.rs1_val << alu_b[4:0];
			SLT: alu_res = {31'b0, $signed(op.rs1_val) < $signed(alu_b)};
			SLTU: alu_res = {31'b0, op.rs1_val < alu_b};
			XOR: alu_res = op.rs1_val ^ alu_b;
			SRL: alu_res = op.rs1_val >> alu_b[4:0];
			SRA: alu_res = $signed(op.rs1_val) >>> alu_b[4:0];
			OR: alu_res = op.rs1_val | alu_b;
			AND: alu_res = op.rs1_val & alu_b;
			default: alu_res = '0;
		endcase
	end

	always_comb begin
		case (op.funct3)
			3'b000: taken = (op.rs1_val == op.rs2_val);
			3'b001: taken = (op.rs1_val != op.rs2_val);
			3'b100: taken = ($signed(op.rs1_val) < $signed(op.rs2_val));
			3'b101: taken = ($signed(op.rs1_val) >= $signed(op.rs2_val));
			3'b110: taken = (op.rs1_val < op.rs2_val);
			default: taken = (op.rs1_val >= op.rs2_val);
		endcase
	end

	always_comb begin
		rec.pc = op.pc;
		rec.rd_idx = op.rd_idx;
		rec.rd_we = op.rd_we;
		rec.rd_data = alu_res;
		rec.next_pc = pc_seq;
		case (op.op_class)
			CLS_LUI: rec.rd_data = op.imm;
			CLS_AUIPC: rec.rd_data = pc_rel;
			CLS_JAL: begin
				rec.rd_data = pc_seq;
				rec.next_pc = {pc_rel[31:2], 2'b00};
			end
			CLS_JALR: begin
				// alu adds rs1 and imm for the target
				rec.rd_data = pc_seq;
				rec.next_pc = {alu_res[31:2], 2'b00};
			end
			CLS_BRANCH: begin
				rec.rd_data = '0;
				rec.next_pc = taken ? {pc_rel[31:2], 2'b00} : pc_seq;
			end
			CLS_UNSUPPORTED: rec.rd_data = '0;
			default: rec.rd_data = alu_res;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			retire_vld <= 1'b0;
		end else begin
			retire_vld <= op_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (op_vld) begin
			retire <= rec;
		end
	end

	// one instruction in flight across fetch, decode and execute
	assert property (@(posedge clk) disable iff (reset) retire_vld |=> !retire_vld);

endmodule

`default_nettype wire

// ==== verilog/core_idu.sv ====
// Instruction decode unit
`timescale 1ns/1ps
`default_nettype none

module core_idu (
	input logic clk,
	input logic reset,
	input logic item_vld,
	input core_pkg::fetch_item_t item,
	output core_pkg::reg_idx_t rs1_idx,
	output core_pkg::reg_idx_t rs2_idx,
	input core_pkg::word_t rs1_val,
	input core_pkg::word_t rs2_val,
	output logic op_vld,
	output core_pkg::decoded_op_t op
);
	import core_pkg::*;

	opcode_t opcode;
	logic [2:0] funct3;
	logic alt;
	word_t imm_i;
	word_t imm_u;
	word_t imm_j;
	word_t imm_b;
	alu_op_e alu_sel;
	decoded_op_t dec;

	assign opcode = item.inst[6:0];
	assign funct3 = item.inst[14:12];
	// funct7 bit 30 picks sub and sra
	assign alt = item.inst[30];
	assign rs1_idx = item.inst[19:15];
	assign rs2_idx = item.inst[24:20];

	assign imm_i = {{20{item.inst[31]}}, item.inst[31:20]};
	assign imm_u = {item.inst[31:12], 12'b0};
	assign imm_j = {{12{item.inst[31]}}, item.inst[19:12], item.inst[20], item.inst[30:21], 1'b0};
	assign imm_b = {{20{item.inst[31]}}, item.inst[7], item.inst[30:25], item.inst[11:8], 1'b0};

	always_comb begin
		case (funct3)
			3'b000: alu_sel = (alt && opcode == OPC_OP) ? SUB : ADD;
			3'b001: alu_sel = SLL;
			3'b010: alu_sel = SLT;
			3'b011: alu_sel = SLTU;
			3'b100: alu_sel = XOR;
			3'b101: alu_sel = alt ? SRA : SRL;
			3'b110: alu_sel = OR;
			default: alu_sel = AND;
		endcase
	end

	always_comb begin
		dec.pc = item.pc;
		dec.funct3 = funct3;
		dec.rs1_val = rs1_val;
		dec.rs2_val = rs2_val;
		dec.rd_idx = item.inst[11:7];
		dec.alu_op = ADD;
		dec.imm = imm_i;
		case (opcode)
			OPC_LUI: begin
				dec.op_class = CLS_LUI;
				dec.imm = imm_u;
			end
			OPC_AUIPC: begin
				dec.op_class = CLS_AUIPC;
				dec.imm = imm_u;
			end
			OPC_JAL: begin
				dec.op_class = CLS_JAL;
				dec.imm = imm_j;
			end
			OPC_JALR: dec.op_class = CLS_JALR;
			OPC_BRANCH: begin
				// funct3 010 and 011 are not branches
				dec.op_class = (funct3[2:1] == 2'b01) ? CLS_UNSUPPORTED : CLS_BRANCH;
				dec.imm = imm_b;
			end
			OPC_OP_IMM: begin
				dec.op_class = CLS_ALU_IMM;
				dec.alu_op = alu_sel;
			end
			OPC_OP: begin
				dec.op_class = CLS_ALU_REG;
				dec.alu_op = alu_sel;
			end
			default: dec.op_class = CLS_UNSUPPORTED;
		endcase
		dec.rd_we = (dec.op_class != CLS_BRANCH) && (dec.op_class != CLS_UNSUPPORTED);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_vld <= 1'b0;
		end else begin
			op_vld <= item_vld;
		end
	end

	// operands captured with the decode
	always_ff @(posedge clk) begin
		if (item_vld) begin
			op <= dec;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/core_ifu.sv ====
// Instruction fetch unit
`timescale 1ns/1ps
`default_nettype none

module core_ifu #(
	parameter core_pkg::word_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	output logic fetch_addr_vld,
	output core_pkg::word_t fetch_addr,
	input logic fetch_inst_vld,
	input core_pkg::word_t fetch_inst,
	input logic retire_vld,
	input core_pkg::retire_t retire,
	output logic item_vld,
	output core_pkg::fetch_item_t item
);
	import core_pkg::*;

	fetch_state_e state;
	word_t pc;

	// request held as a level while waiting on the bus
	assign fetch_addr_vld = (state == FETCH_REQ);
	assign fetch_addr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH_RESET;
			pc <= RESET_PC;
			item_vld <= 1'b0;
		end else begin
			item_vld <= 1'b0;
			case (state)
				FETCH_RESET: begin
					state <= FETCH_REQ;
				end
				FETCH_REQ: begin
					if (fetch_inst_vld) begin
						item_vld <= 1'b1;
						state <= FETCH_WAIT_RETIRE;
					end
				end
				FETCH_WAIT_RETIRE: begin
					// every retire redirects to its next_pc
					if (retire_vld) begin
						pc <= retire.next_pc;
						state <= FETCH_REQ;
					end
				end
				default: begin
					state <= FETCH_RESET;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_addr_vld && fetch_inst_vld) begin
			item <= '{pc: pc, inst: fetch_inst};
		end
	end

	// bus answers only an open request
	assert property (@(posedge clk) disable iff (reset) fetch_inst_vld |-> fetch_addr_vld);

	assert property (@(posedge clk) disable iff (reset) fetch_addr_vld |-> fetch_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/core_gpr.sv ====
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module core_gpr (
	input logic clk,
	input core_pkg::reg_idx_t rs1_idx,
	input core_pkg::reg_idx_t rs2_idx,
	output core_pkg::word_t rs1_val,
	output core_pkg::word_t rs2_val,
	input logic retire_vld,
	input core_pkg::retire_t retire
);
	import core_pkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (retire_vld && retire.rd_we && retire.rd_idx != 5'd0) begin
			regs[retire.rd_idx] <= retire.rd_data;
		end
	end

	assign rs1_val = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
	assign rs2_val = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
// Core shared types
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;

	// major opcodes of the supported subset
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_AUIPC = 7'b0010111;
	localparam opcode_t OPC_JAL = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP = 7'b0110011;

	typedef enum logic [2:0] {
		CLS_LUI,
		CLS_AUIPC,
		CLS_JAL,
		CLS_JALR,
		CLS_BRANCH,
		CLS_ALU_IMM,
		CLS_ALU_REG,
		CLS_UNSUPPORTED
	} op_class_e;

	typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_e;

	typedef enum logic [1:0] {FETCH_REQ, FETCH_WAIT_RETIRE, FETCH_RESET} fetch_state_e;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_item_t;

	typedef struct packed {
		word_t pc;
		op_class_e op_class;
		alu_op_e alu_op;
		// branch condition select
		logic [2:0] funct3;
		word_t rs1_val;
		word_t rs2_val;
		word_t imm;
		reg_idx_t rd_idx;
		logic rd_we;
	} decoded_op_t;

	// commit record of one instruction
	typedef struct packed {
		word_t pc;
		reg_idx_t rd_idx;
		logic rd_we;
		word_t rd_data;
		word_t next_pc;
	} retire_t;

endpackage

`default_nettype wire
